// ==== Bender.yml ====
package:
  name: cpu

sources:
  - source/cpu_pkg.sv
  - source/regs.sv
  - source/fetcher.sv
  - source/decoder.sv
  - source/alu.sv
  - source/branch.sv
  - source/memory.sv
  - source/cpu.sv
  - target: test
    files:
      - dv/cpu_tb.sv

// ==== cpu.f ====
source/cpu_pkg.sv
source/regs.sv
source/fetcher.sv
source/decoder.sv
source/alu.sv
source/branch.sv
source/memory.sv
source/cpu.sv
dv/cpu_tb.sv

// ==== dv/cpu_tb.sv ====
`default_nettype none

module cpu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] start_pc   = 32'h0000_0080;
    localparam int          imem_words = 128;
    localparam int          max_trace  = 64;
    localparam int          max_cycles = 2000;
    localparam logic [6:0]  load_op    = 7'b0000011;
    localparam logic [6:0]  store_op   = 7'b0100011;

    logic        clk;
    logic        rstn;
    logic        imem_ack;
    logic [31:0] imem_data;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        retire;
    logic [31:0] retire_pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    // program image and expected retire trace
    logic [31:0] imem [imem_words];
    logic        imem_valid [imem_words];
    logic [31:0] exp_pc [max_trace];
    logic        exp_we [max_trace];
    logic [4:0]  exp_rd [max_trace];
    logic [31:0] exp_val [max_trace];
    int          n_exp;
    int          ret_idx;
    int          errors;
    integer      seed;
    logic        loaded;

    cpu #(.reset_pc(start_pc), .dmem_words(256)) dut_i (
        .clk(clk), .rstn(rstn), .imem_ack(imem_ack), .imem_data(imem_data),
        .imem_req(imem_req), .imem_addr(imem_addr), .retire(retire),
        .retire_pc(retire_pc), .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
    );

    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("Fail %0t: %s is %h, expected %h", $time, field, got, expected);
        errors++;
    endtask

    // loads and stores spend two more cycles in execute wait
    function automatic int retire_latency(input logic [31:0] word);
        int latency;
        if (word[6:0] == load_op || word[6:0] == store_op) begin
            latency = 6;
        end else begin
            latency = 4;
        end
        return latency;
    endfunction

    task automatic load_testdata(output logic ok);
        integer        fd;
        integer        code;
        int            i;
        int            we;
        int            rd;
        logic [63:0]   tag;
        logic [1023:0] line;
        logic [31:0]   addr;
        logic [31:0]   word;
        logic          done;
        ok    = 1'b0;
        n_exp = 0;
        for (i = 0; i < imem_words; i++) begin
            imem[i]       = '0;
            imem_valid[i] = 1'b0;
        end
        fd = $fopen("dv/cpu_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file dv/cpu_testdata.txt");
            errors++;
        end else begin
            done = 1'b0;
            while (!done) begin
                tag  = '0;
                code = $fscanf(fd, " %s", tag);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tag == "#") begin
                    code = $fgets(line, fd);
                end else if (tag == "I") begin
                    code = $fscanf(fd, " %h %h", addr, word);
                    if (addr < imem_words * 4) begin
                        imem[addr[8:2]]       = word;
                        imem_valid[addr[8:2]] = 1'b1;
                    end else begin
                        $display("instruction address %h in the data file is too large", addr);
                        errors++;
                    end
                end else if (tag == "W" && n_exp < max_trace) begin
                    code = $fscanf(fd, " %h %d %d %h", addr, we, rd, word);
                    exp_pc[n_exp]  = addr;
                    exp_we[n_exp]  = we != 0;
                    exp_rd[n_exp]  = rd[4:0];
                    exp_val[n_exp] = word;
                    n_exp++;
                end else begin
                    $display("unexpected entry in the test data file");
                    errors++;
                    done = 1'b1;
                end
            end
            $fclose(fd);
            if (n_exp == 0) begin
                $display("the test data file holds no expected retires");
                errors++;
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    // instruction port model and trace checker, one pass per falling edge
    task automatic run_program;
        int          cycle;
        int          ack_wait;
        int          ack_cycle;
        int          exp_latency;
        int          fetch_count;
        logic        retire_due;
        logic [31:0] fetch_word;
        cycle       = 0;
        ack_wait    = 0;
        ack_cycle   = 0;
        exp_latency = 0;
        fetch_count = 0;
        retire_due  = 1'b0;
        fetch_word  = '0;
        while (ret_idx < n_exp && cycle < max_cycles) begin
            @(negedge clk);
            cycle++;
            if (retire) begin
                if (!retire_due) begin
                    $display("Fail %0t: retire pulse with no instruction in flight", $time);
                    errors++;
                end else if (cycle - ack_cycle != exp_latency) begin
                    $display("Fail %0t: retire came %0d cycles after the acknowledge, expected %0d",
                             $time, cycle - ack_cycle, exp_latency);
                    errors++;
                end
                if (retire_pc !== exp_pc[ret_idx]) begin
                    report_mismatch("retire_pc", retire_pc, exp_pc[ret_idx]);
                end
                if (wb_en !== exp_we[ret_idx]) begin
                    report_mismatch("wb_en", {31'b0, wb_en}, {31'b0, exp_we[ret_idx]});
                end
                if (exp_we[ret_idx] && wb_addr !== exp_rd[ret_idx]) begin
                    report_mismatch("wb_addr", {27'b0, wb_addr}, {27'b0, exp_rd[ret_idx]});
                end
                if (exp_we[ret_idx] && wb_data !== exp_val[ret_idx]) begin
                    report_mismatch("wb_data", wb_data, exp_val[ret_idx]);
                end
                ret_idx++;
                retire_due = 1'b0;
            end else if (retire_due && cycle - ack_cycle == exp_latency) begin
                $display("Fail %0t: no retire %0d cycles after the acknowledge at pc %h",
                         $time, exp_latency, exp_pc[ret_idx]);
                errors++;
            end
            if (!retire && wb_en) begin
                $display("Fail %0t: wb_en high without a retire pulse", $time);
                errors++;
            end
            // acknowledge pulse lasts one cycle
            imem_ack = 1'b0;
            if (ack_wait > 0) begin
                ack_wait--;
                if (ack_wait == 0) begin
                    imem_ack    = 1'b1;
                    imem_data   = fetch_word;
                    retire_due  = 1'b1;
                    ack_cycle   = cycle;
                    exp_latency = retire_latency(fetch_word);
                end
            end
            if (imem_req) begin
                if (ack_wait > 0 || retire_due) begin
                    $display("a fetch request came while an instruction was still in flight");
                    errors++;
                end
                if (fetch_count == 0 && imem_addr !== start_pc) begin
                    report_mismatch("first imem_addr", imem_addr, start_pc);
                end
                if (fetch_count < n_exp && imem_addr !== exp_pc[fetch_count]) begin
                    report_mismatch("imem_addr", imem_addr, exp_pc[fetch_count]);
                end
                if (imem_addr[1:0] == 2'b00 && imem_addr < imem_words * 4
                    && imem_valid[imem_addr[8:2]]) begin
                    fetch_word = imem[imem_addr[8:2]];
                end else begin
                    $display("fetch from address %h outside the loaded program", imem_addr);
                    errors++;
                    fetch_word = '0;
                end
                fetch_count++;
                ack_wait = 1 + ($unsigned($random(seed)) % 5);
            end
        end
        if (ret_idx < n_exp) begin
            $display("timeout after %0d cycles with %0d of %0d instructions retired",
                     cycle, ret_idx, n_exp);
            errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        rstn      = 1'b0;
        imem_ack  = 1'b0;
        imem_data = '0;
        errors    = 0;
        ret_idx   = 0;
        seed      = 63487;
        load_testdata(loaded);
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        if (loaded) begin
            run_program();
        end
        $display("errors: %0d, retired %0d of %0d instructions", errors, ret_idx, n_exp);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/cpu_testdata.txt ====
# I <byte address, hex> <instruction word, hex>
# W <retire pc, hex> <writes rd, 0 or 1> <rd, decimal> <written value, hex>
I 080 123450B7
I 084 FFB00113
I 088 00300193
I 08C 40218233
I 090 403152B3
I 094 00312333
I 098 003133B3
I 09C 7FF0E413
I 0A0 00802823
I 0A4 00200A23
I 0A8 00201B23
I 0AC 01002483
I 0B0 01400503
I 0B4 01404583
I 0B8 01601603
I 0BC 01605683
I 0C0 00918013
I 0C4 00300733
I 0C8 00E18463
I 0D0 00E19463
I 0D4 00315463
I 0D8 0021E463
I 0E0 010007EF
I 0F0 02078867
I 104 003148B3
I 108 00315933
W 080 1 1 12345000
W 084 1 2 FFFFFFFB
W 088 1 3 00000003
W 08C 1 4 00000008
W 090 1 5 FFFFFFFF
W 094 1 6 00000001
W 098 1 7 00000000
W 09C 1 8 123457FF
W 0A0 0 0 00000000
W 0A4 0 0 00000000
W 0A8 0 0 00000000
W 0AC 1 9 123457FF
W 0B0 1 10 FFFFFFFB
W 0B4 1 11 000000FB
W 0B8 1 12 FFFFFFFB
W 0BC 1 13 0000FFFB
W 0C0 0 0 00000000
W 0C4 1 14 00000003
W 0C8 0 0 00000000
W 0D0 0 0 00000000
W 0D4 0 0 00000000
W 0D8 0 0 00000000
W 0E0 1 15 000000E4
W 0F0 1 16 000000F4
W 104 1 17 FFFFFFF8
W 108 1 18 1FFFFFFF

// ==== source/alu.sv ====
`default_nettype none

module alu (
    input  wire cpu_pkg::funct3_t funct3,
    input  wire                   alt,
    input  wire cpu_pkg::word_t   a,
    input  wire cpu_pkg::word_t   b,
    output cpu_pkg::word_t        result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (funct3)
            cpu_pkg::f3_add:  result = alt ? a - b : a + b;
            cpu_pkg::f3_sll:  result = a << shamt;
            cpu_pkg::f3_slt:  result = {31'b0, $signed(a) < $signed(b)};
            cpu_pkg::f3_sltu: result = {31'b0, a < b};
            cpu_pkg::f3_xor:  result = a ^ b;
            // alt picks arithmetic shift
            cpu_pkg::f3_sr:   result = alt ? $unsigned($signed(a) >>> shamt) : a >> shamt;
            cpu_pkg::f3_or:   result = a | b;
            cpu_pkg::f3_and:  result = a & b;
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/branch.sv ====
`default_nettype none

module branch (
    input  wire cpu_pkg::funct3_t funct3,
    input  wire cpu_pkg::word_t   a,
    input  wire cpu_pkg::word_t   b,
    output logic                  taken
);

    always_comb begin
        case (funct3)
            cpu_pkg::f3_beq:  taken = a == b;
            cpu_pkg::f3_bne:  taken = a != b;
            cpu_pkg::f3_blt:  taken = $signed(a) < $signed(b);
            cpu_pkg::f3_bge:  taken = $signed(a) >= $signed(b);
            cpu_pkg::f3_bltu: taken = a < b;
            cpu_pkg::f3_bgeu: taken = a >= b;
            // 010 and 011 are not branches
            default:          taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cpu.sv ====
`default_nettype none

module cpu #(
    parameter cpu_pkg::word_t reset_pc   = '0,
    parameter int             dmem_words = 256
) (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 imem_ack,
    input  wire cpu_pkg::inst_t imem_data,
    output logic                imem_req,
    output cpu_pkg::word_t      imem_addr,
    output logic                retire,
    output cpu_pkg::word_t      retire_pc,
    output logic                wb_en,
    output cpu_pkg::reg_addr_t  wb_addr,
    output cpu_pkg::word_t      wb_data
);

    cpu_pkg::state_t    state;
    cpu_pkg::word_t     pc;
    cpu_pkg::word_t     pc_plus4;

    // fetch to decode
    logic               fetch_order;
    logic               fetched;
    cpu_pkg::inst_t     inst_f;
    cpu_pkg::inst_t     inst_fd;

    // decoder outputs
    cpu_pkg::reg_addr_t rs1_addr;
    cpu_pkg::reg_addr_t rs2_addr;
    cpu_pkg::word_t     rs1_data;
    cpu_pkg::word_t     rs2_data;
    logic               alu_d;
    logic               mem_d;
    logic               branch_d;
    logic               jump_d;
    logic               subst_d;
    cpu_pkg::word_t     a_d;
    cpu_pkg::word_t     b_d;
    cpu_pkg::word_t     c_d;
    cpu_pkg::reg_addr_t rd_d;
    cpu_pkg::opcode_t   opcode_d;
    cpu_pkg::funct3_t   funct3_d;
    cpu_pkg::funct7_t   funct7_d;
    logic               writes_rd_d;

    // decode to execute
    logic               alu_de;
    logic               mem_de;
    logic               branch_de;
    logic               jump_de;
    logic               subst_de;
    logic               writes_rd_de;
    cpu_pkg::word_t     a_de;
    cpu_pkg::word_t     b_de;
    cpu_pkg::word_t     c_de;
    cpu_pkg::reg_addr_t rd_de;
    cpu_pkg::opcode_t   opcode_de;
    cpu_pkg::funct3_t   funct3_de;
    cpu_pkg::funct7_t   funct7_de;

    // execute to write
    logic               write_ew;
    cpu_pkg::word_t     d_rd_ew;
    cpu_pkg::word_t     next_pc_ew;

    cpu_pkg::word_t     alu_result;
    logic               taken;
    logic               mem_flag;
    logic               mem_store;
    logic               mem_accessed;
    cpu_pkg::word_t     load_data;

    assign pc_plus4 = pc + 32'd4;

    regs regs_i (
        .clk(clk), .rstn(rstn), .we(wb_en), .rd_addr(wb_addr),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    fetcher fetcher_i (
        .clk(clk), .rstn(rstn), .fetch_order(fetch_order), .pc(pc),
        .imem_ack(imem_ack), .imem_data(imem_data), .imem_req(imem_req),
        .imem_addr(imem_addr), .fetched(fetched), .inst(inst_f)
    );

    decoder decoder_i (
        .inst(inst_fd), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .is_alu(alu_d), .is_mem(mem_d), .is_branch(branch_d),
        .is_jump(jump_d), .is_subst(subst_d),
        .operand_a(a_d), .operand_b(b_d), .operand_c(c_d), .rd_addr(rd_d),
        .opcode(opcode_d), .funct3(funct3_d), .funct7(funct7_d),
        .writes_rd(writes_rd_d)
    );

    alu alu_i (
        .funct3(funct3_de), .alt(funct7_de[5]), .a(a_de), .b(b_de),
        .result(alu_result)
    );

    branch branch_i (.funct3(funct3_de), .a(a_de), .b(b_de), .taken(taken));

    memory #(.dmem_words(dmem_words)) memory_i (
        .clk(clk), .rstn(rstn), .mem_flag(mem_flag), .mem_store(mem_store),
        .funct3(funct3_de), .addr(a_de), .store_data(c_de),
        .mem_accessed(mem_accessed), .load_data(load_data)
    );

    // sequencer and control state
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= cpu_pkg::st_fetch;
            pc           <= reset_pc;
            fetch_order  <= 1'b0;
            mem_flag     <= 1'b0;
            mem_store    <= 1'b0;
            write_ew     <= 1'b0;
            retire       <= 1'b0;
            wb_en        <= 1'b0;
            alu_de       <= 1'b0;
            mem_de       <= 1'b0;
            branch_de    <= 1'b0;
            jump_de      <= 1'b0;
            subst_de     <= 1'b0;
            writes_rd_de <= 1'b0;
        end else begin
            retire <= 1'b0;
            wb_en  <= 1'b0;
            case (state)
                cpu_pkg::st_fetch: begin
                    fetch_order <= 1'b1;
                    state       <= cpu_pkg::st_fetch_wait;
                end
                cpu_pkg::st_fetch_wait: begin
                    fetch_order <= 1'b0;
                    if (fetched) begin
                        state <= cpu_pkg::st_decode;
                    end
                end
                cpu_pkg::st_decode: begin
                    alu_de       <= alu_d;
                    mem_de       <= mem_d;
                    branch_de    <= branch_d;
                    jump_de      <= jump_d;
                    subst_de     <= subst_d;
                    writes_rd_de <= writes_rd_d;
                    state        <= cpu_pkg::st_execute;
                end
                cpu_pkg::st_execute: begin
                    write_ew <= writes_rd_de;
                    if (mem_de) begin
                        mem_flag  <= 1'b1;
                        mem_store <= opcode_de == cpu_pkg::op_store;
                        state     <= cpu_pkg::st_execute_wait;
                    end else begin
                        state <= cpu_pkg::st_write;
                    end
                end
                cpu_pkg::st_execute_wait: begin
                    mem_flag <= 1'b0;
                    if (mem_accessed) begin
                        state <= cpu_pkg::st_write;
                    end
                end
                cpu_pkg::st_write: begin
                    retire <= 1'b1;
                    wb_en  <= write_ew;
                    pc     <= next_pc_ew;
                    state  <= cpu_pkg::st_fetch;
                end
                default: state <= cpu_pkg::st_fetch;
            endcase
        end
    end

    // stage payload
    always_ff @(posedge clk) begin
        case (state)
            cpu_pkg::st_fetch_wait: begin
                if (fetched) begin
                    inst_fd <= inst_f;
                end
            end
            cpu_pkg::st_decode: begin
                a_de      <= a_d;
                b_de      <= b_d;
                c_de      <= c_d;
                rd_de     <= rd_d;
                opcode_de <= opcode_d;
                funct3_de <= funct3_d;
                funct7_de <= funct7_d;
            end
            cpu_pkg::st_execute: begin
                next_pc_ew <= pc_plus4;
                if (alu_de) begin
                    d_rd_ew <= alu_result;
                end else if (branch_de && taken) begin
                    next_pc_ew <= c_de;
                end else if (jump_de) begin
                    // link value
                    next_pc_ew <= c_de;
                    d_rd_ew    <= pc_plus4;
                end else if (subst_de) begin
                    d_rd_ew <= c_de;
                end
            end
            cpu_pkg::st_execute_wait: begin
                if (mem_accessed) begin
                    d_rd_ew <= load_data;
                end
            end
            cpu_pkg::st_write: begin
                retire_pc <= pc;
                wb_addr   <= rd_de;
                wb_data   <= d_rd_ew;
            end
            default: ;
        endcase
    end

    state_legal: assert property (@(posedge clk) disable iff (!rstn)
        state inside {cpu_pkg::st_fetch, cpu_pkg::st_fetch_wait, cpu_pkg::st_decode,
                      cpu_pkg::st_execute, cpu_pkg::st_execute_wait, cpu_pkg::st_write});

endmodule

`default_nettype wire

// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [31:0]           inst_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [6:0]            funct7_t;

    // major opcodes
    localparam opcode_t op_alu_r  = 7'b0110011;
    localparam opcode_t op_alu_i  = 7'b0010011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_lui    = 7'b0110111;

    // alu functions
    localparam funct3_t f3_add  = 3'b000;
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_sr   = 3'b101;
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;

    // branch conditions
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    // access sizes, stores share the low encodings
    localparam funct3_t f3_lb  = 3'b000;
    localparam funct3_t f3_lh  = 3'b001;
    localparam funct3_t f3_lw  = 3'b010;
    localparam funct3_t f3_lbu = 3'b100;
    localparam funct3_t f3_lhu = 3'b101;

    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_execute,
        st_execute_wait,
        st_write
    } state_t;

endpackage

`default_nettype wire

// ==== source/decoder.sv ====
`default_nettype none

module decoder (
    input  wire cpu_pkg::inst_t  inst,
    input  wire cpu_pkg::word_t  pc,
    input  wire cpu_pkg::word_t  rs1_data,
    input  wire cpu_pkg::word_t  rs2_data,
    output cpu_pkg::reg_addr_t   rs1_addr,
    output cpu_pkg::reg_addr_t   rs2_addr,
    output logic                 is_alu,
    output logic                 is_mem,
    output logic                 is_branch,
    output logic                 is_jump,
    output logic                 is_subst,
    output cpu_pkg::word_t       operand_a,
    output cpu_pkg::word_t       operand_b,
    output cpu_pkg::word_t       operand_c,
    output cpu_pkg::reg_addr_t   rd_addr,
    output cpu_pkg::opcode_t     opcode,
    output cpu_pkg::funct3_t     funct3,
    output cpu_pkg::funct7_t     funct7,
    output logic                 writes_rd
);

    cpu_pkg::word_t imm_i;
    cpu_pkg::word_t imm_s;
    cpu_pkg::word_t imm_b;
    cpu_pkg::word_t imm_u;
    cpu_pkg::word_t imm_j;
    logic           shift_i;

    assign opcode   = inst[6:0];
    assign rd_addr  = inst[11:7];
    assign funct3   = inst[14:12];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign is_alu    = opcode == cpu_pkg::op_alu_r || opcode == cpu_pkg::op_alu_i;
    assign is_mem    = opcode == cpu_pkg::op_load || opcode == cpu_pkg::op_store;
    assign is_branch = opcode == cpu_pkg::op_branch;
    assign is_jump   = opcode == cpu_pkg::op_jal || opcode == cpu_pkg::op_jalr;
    assign is_subst  = opcode == cpu_pkg::op_lui;

    // immediate alu ops only carry funct7 for shifts, elsewhere it is immediate bits
    assign shift_i = opcode == cpu_pkg::op_alu_i
                     && (funct3 == cpu_pkg::f3_sll || funct3 == cpu_pkg::f3_sr);
    assign funct7  = (opcode == cpu_pkg::op_alu_r || shift_i) ? inst[31:25] : '0;

    assign writes_rd = (is_alu || is_jump || is_subst || opcode == cpu_pkg::op_load)
                       && rd_addr != '0;

    always_comb begin
        operand_a = rs1_data;
        operand_b = rs2_data;
        operand_c = rs2_data;
        case (opcode)
            cpu_pkg::op_alu_i: operand_b = imm_i;
            cpu_pkg::op_load: begin
                operand_a = rs1_data + imm_i;
                operand_b = imm_i;
            end
            cpu_pkg::op_store: begin
                operand_a = rs1_data + imm_s;
                operand_b = imm_s;
            end
            cpu_pkg::op_branch: operand_c = pc + imm_b;
            cpu_pkg::op_jal:    operand_c = pc + imm_j;
            cpu_pkg::op_jalr:   operand_c = (rs1_data + imm_i) & ~32'd1;
            cpu_pkg::op_lui:    operand_c = imm_u;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/fetcher.sv ====
`default_nettype none

module fetcher (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 fetch_order,
    input  wire cpu_pkg::word_t pc,
    input  wire                 imem_ack,
    input  wire cpu_pkg::inst_t imem_data,
    output logic                imem_req,
    output cpu_pkg::word_t      imem_addr,
    output logic                fetched,
    output cpu_pkg::inst_t      inst
);

    logic busy;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            imem_req <= 1'b0;
            busy     <= 1'b0;
        end else begin
            // one-cycle request per order
            imem_req <= fetch_order;
            if (fetch_order) begin
                busy <= 1'b1;
            end else if (imem_ack) begin
                busy <= 1'b0;
            end
        end
    end

    // address held until the next order
    always_ff @(posedge clk) begin
        if (fetch_order) begin
            imem_addr <= pc;
        end
    end

    assign fetched = imem_ack && busy;
    assign inst    = imem_data;

    ack_pending: assert property (@(posedge clk) disable iff (!rstn) imem_ack |-> busy);
    order_idle: assert property (@(posedge clk) disable iff (!rstn) fetch_order |-> !busy);

endmodule

`default_nettype wire

// ==== source/memory.sv ====
`default_nettype none

module memory #(
    parameter int dmem_words = 256
) (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   mem_flag,
    input  wire                   mem_store,
    input  wire cpu_pkg::funct3_t funct3,
    input  wire cpu_pkg::word_t   addr,
    input  wire cpu_pkg::word_t   store_data,
    output logic                  mem_accessed,
    output cpu_pkg::word_t        load_data
);

    localparam int idx_w = $clog2(dmem_words);

    cpu_pkg::word_t   mem_q [dmem_words];
    logic [idx_w-1:0] word_idx;
    logic [3:0]       byte_en;
    cpu_pkg::word_t   wdata;
    cpu_pkg::word_t   rdata;

    assign word_idx = addr[idx_w+1:2];
    assign rdata    = mem_q[word_idx] >> {addr[1:0], 3'b000};

    // replicate narrow data across lanes, enables pick the lane
    always_comb begin
        case (funct3)
            cpu_pkg::f3_lb: begin
                byte_en = 4'b0001 << addr[1:0];
                wdata   = {4{store_data[7:0]}};
            end
            cpu_pkg::f3_lh: begin
                byte_en = 4'b0011 << {addr[1], 1'b0};
                wdata   = {2{store_data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wdata   = store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_flag && mem_store) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem_q[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_accessed <= 1'b0;
        end else begin
            mem_accessed <= mem_flag;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_flag) begin
            case (funct3)
                cpu_pkg::f3_lb:  load_data <= {{24{rdata[7]}}, rdata[7:0]};
                cpu_pkg::f3_lh:  load_data <= {{16{rdata[15]}}, rdata[15:0]};
                cpu_pkg::f3_lbu: load_data <= {24'b0, rdata[7:0]};
                cpu_pkg::f3_lhu: load_data <= {16'b0, rdata[15:0]};
                default:         load_data <= rdata;
            endcase
        end
    end

    addr_range: assert property (@(posedge clk) disable iff (!rstn)
        mem_flag |-> (addr >> 2) < dmem_words);

endmodule

`default_nettype wire

// ==== source/regs.sv ====
`default_nettype none

module regs (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     we,
    input  wire cpu_pkg::reg_addr_t rd_addr,
    input  wire cpu_pkg::reg_addr_t rs1_addr,
    input  wire cpu_pkg::reg_addr_t rs2_addr,
    input  wire cpu_pkg::word_t     rd_data,
    output cpu_pkg::word_t          rs1_data,
    output cpu_pkg::word_t          rs2_data
);

    cpu_pkg::word_t regs_q [32];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin
            // x0 is hardwired, writes to it vanish
            regs_q[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs_q[rs1_addr];
    assign rs2_data = regs_q[rs2_addr];

    x0_zero: assert property (@(posedge clk) disable iff (!rstn) regs_q[0] == '0);

endmodule

`default_nettype wire
